//--- decode_stage.f
+incdir+src
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/decode_pipe_reg.sv
src/decode_stage.sv
sim/decode_stage_chk.sv
sim/decode_stage_tb.sv

//--- Makefile
# Verilator flow for the decode stage.

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
RTL_TOP   ?= decode_stage
FLIST     ?= decode_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SRCS     := $(shell grep -v '^+' $(FLIST))
RTL_SRCS := $(filter src/%,$(SRCS))
HDRS     := $(wildcard src/*.svh)
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+src $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run counts as passed only if the pass line shows up in its output.
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/decode_stage_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_stage_tb import rv_isa_pkg::*, decode_pkg::*; ();

  localparam int MAX_CYCLES = 2000; // the full sequence takes roughly 600 cycles.

  typedef struct packed {
    logic [`DEC_XLEN-1:0]    pc;
    dec_op_e                 op;
    logic [`DEC_REGNO_W-1:0] r1;
    logic [`DEC_REGNO_W-1:0] r2;
    logic [`DEC_REGNO_W-1:0] rd;
    logic [`DEC_XLEN-1:0]    v1;
    logic [`DEC_XLEN-1:0]    v2;
    logic [`DEC_XLEN-1:0]    imm;
  } exp_t;

  logic                    clk;
  logic                    rst_n;
  logic                    decode_en;
  logic                    branch_taken;
  logic                    syscall_flush;
  logic [`DEC_ILEN-1:0]    instr;
  logic [`DEC_XLEN-1:0]    pc_plus4;
  logic                    wb_en;
  logic [`DEC_REGNO_W-1:0] wb_regno;
  logic [`DEC_XLEN-1:0]    wb_value;
  logic [`DEC_XLEN-1:0]    out_pc_plus4;
  dec_op_e                 out_op;
  logic [`DEC_REGNO_W-1:0] out_rs1_regno;
  logic [`DEC_REGNO_W-1:0] out_rs2_regno;
  logic [`DEC_REGNO_W-1:0] out_rd_regno;
  logic [`DEC_XLEN-1:0]    out_rs1_value;
  logic [`DEC_XLEN-1:0]    out_rs2_value;
  logic [`DEC_XLEN-1:0]    out_imm;
  logic [`DEC_XLEN-1:0]    taps [8];

  logic [`DEC_XLEN-1:0]    model [`DEC_NREGS];
  logic                    pend_wen;
  logic [`DEC_REGNO_W-1:0] pend_reg;
  logic [`DEC_XLEN-1:0]    pend_val;
  exp_t                    cur;
  exp_t                    exp_q [$];
  int                      due_q [$];
  string                   name_q [$];
  int                      cycle = 0;
  int                      errors = 0;
  int                      checks = 0;
  logic                    taps_on = 1'b0;
  integer                  seed = 45;
  major_op_e               majors [12] = '{maj_lui, maj_auipc, maj_jal, maj_jalr,
                                           maj_branch, maj_load, maj_store, maj_op_imm,
                                           maj_op, maj_op_imm_32, maj_op_32, maj_system};

  decode_stage DUT (
    .clk (clk), .rst_n (rst_n), .decode_en (decode_en), .branch_taken (branch_taken),
    .syscall_flush (syscall_flush), .instr (instr), .pc_plus4 (pc_plus4),
    .wb_en (wb_en), .wb_regno (wb_regno), .wb_value (wb_value),
    .out_pc_plus4 (out_pc_plus4), .out_op (out_op), .out_rs1_regno (out_rs1_regno),
    .out_rs2_regno (out_rs2_regno), .out_rd_regno (out_rd_regno),
    .out_rs1_value (out_rs1_value), .out_rs2_value (out_rs2_value), .out_imm (out_imm),
    .a0 (taps[0]), .a1 (taps[1]), .a2 (taps[2]), .a3 (taps[3]),
    .a4 (taps[4]), .a5 (taps[5]), .a6 (taps[6]), .a7 (taps[7])
  );

  bind decode_stage decode_stage_chk u_chk (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [`DEC_XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // expected decode, built from the RV64I encoding tables.
  function automatic void ref_decode(input logic [31:0] w, output dec_op_e op,
                                     output logic [4:0] r1, output logic [4:0] r2,
                                     output logic [4:0] rd, output logic [63:0] imm);
    logic [2:0]         f3;
    logic [9:0]         f73;
    logic               rtype;
    imm_fmt_e           fmt;
    logic signed [63:0] sx;
    f3    = w[14:12];
    f73   = {w[31:25], f3};
    op    = op_illegal;
    fmt   = imm_none;
    rtype = 1'b0;
    case (w[6:0])
      maj_lui, maj_auipc: fmt = imm_u;
      maj_jal: fmt = imm_j;
      maj_jalr, maj_load, maj_op_imm, maj_op_imm_32: fmt = imm_i;
      maj_store: fmt = imm_s;
      maj_branch: fmt = imm_b;
      maj_op, maj_op_32: rtype = 1'b1;
      default: fmt = imm_none;
    endcase
    case (w[6:0])
      maj_lui: op = op_lui;
      maj_auipc: op = op_auipc;
      maj_jal: op = op_jal;
      maj_jalr: op = (f3 == 3'b000) ? op_jalr : op_illegal;
      maj_branch:
        case (f3)
          br_beq: op = op_beq;
          br_bne: op = op_bne;
          br_blt: op = op_blt;
          br_bge: op = op_bge;
          br_bltu: op = op_bltu;
          br_bgeu: op = op_bgeu;
          default: op = op_illegal;
        endcase
      maj_load:
        case (f3)
          ld_lb: op = op_lb;
          ld_lh: op = op_lh;
          ld_lw: op = op_lw;
          ld_ld: op = op_ld;
          ld_lbu: op = op_lbu;
          ld_lhu: op = op_lhu;
          ld_lwu: op = op_lwu;
          default: op = op_illegal;
        endcase
      maj_store:
        case (f3)
          st_sb: op = op_sb;
          st_sh: op = op_sh;
          st_sw: op = op_sw;
          st_sd: op = op_sd;
          default: op = op_illegal;
        endcase
      maj_op_imm:
        casez ({w[31:26], f3}) // rv64 shifts take a 6-bit shamt.
          9'b??????_000: op = op_addi;
          9'b??????_010: op = op_slti;
          9'b??????_011: op = op_sltiu;
          9'b??????_100: op = op_xori;
          9'b??????_110: op = op_ori;
          9'b??????_111: op = op_andi;
          9'b000000_001: op = op_slli;
          9'b000000_101: op = op_srli;
          9'b010000_101: op = op_srai;
          default: op = op_illegal;
        endcase
      maj_op_imm_32:
        casez (f73)
          10'b???????_000: op = op_addiw;
          10'b0000000_001: op = op_slliw;
          10'b0000000_101: op = op_srliw;
          10'b0100000_101: op = op_sraiw;
          default: op = op_illegal;
        endcase
      maj_op:
        case (f73)
          10'b0000000_000: op = op_add;
          10'b0100000_000: op = op_sub;
          10'b0000000_001: op = op_sll;
          10'b0000000_010: op = op_slt;
          10'b0000000_011: op = op_sltu;
          10'b0000000_100: op = op_xor;
          10'b0000000_101: op = op_srl;
          10'b0100000_101: op = op_sra;
          10'b0000000_110: op = op_or;
          10'b0000000_111: op = op_and;
          default: op = op_illegal;
        endcase
      maj_op_32:
        case (f73)
          10'b0000000_000: op = op_addw;
          10'b0100000_000: op = op_subw;
          10'b0000000_001: op = op_sllw;
          10'b0000000_101: op = op_srlw;
          10'b0100000_101: op = op_sraw;
          default: op = op_illegal;
        endcase
      maj_system:
        if (w[31:7] == 25'h0) op = op_ecall;
        else if (w[31:7] == 25'h2000) op = op_ebreak;
      default: op = op_illegal;
    endcase
    r1 = '0;
    r2 = '0;
    rd = '0;
    if (op != op_illegal && rtype) begin
      rd = w[11:7];
      r1 = w[19:15];
      r2 = w[24:20];
    end else if (op != op_illegal) begin
      case (fmt)
        imm_i: begin
          rd = w[11:7];
          r1 = w[19:15];
        end
        imm_s, imm_b: begin
          r1 = w[19:15];
          r2 = w[24:20];
        end
        imm_u, imm_j: rd = w[11:7];
        default: rd = '0;
      endcase
    end
    case (fmt) // the field is packed at the top and shifted down to sign-extend it.
      imm_i: sx = $signed({w[31:20], 52'd0}) >>> 52;
      imm_s: sx = $signed({w[31:25], w[11:7], 52'd0}) >>> 52;
      imm_b: sx = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 51'd0}) >>> 51;
      imm_u: sx = $signed({w[31:12], 44'd0}) >>> 32;
      imm_j: sx = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 43'd0}) >>> 43;
      default: sx = '0;
    endcase
    imm = (op == op_illegal) ? 64'd0 : sx;
  endfunction

  task automatic build_instr(output logic [31:0] w);
    logic [31:0] r;
    logic [31:0] s;
    major_op_e   opc;
    r = $random(seed);
    s = $random(seed);
    if (s[31:28] == 4'hf) begin
      w = r; // raw word, mostly an unknown opcode.
    end else begin
      opc = majors[s[27:24] % 4'd12];
      w   = {r[31:7], opc};
      if (opc == maj_op || opc == maj_op_32 || opc == maj_op_imm || opc == maj_op_imm_32) begin
        case (s[1:0])
          2'd0: w[31:25] = 7'h00;
          2'd1: w[31:25] = 7'h20;
          2'd2: w[31:25] = 7'h21;
          default: w[31:25] = r[31:25];
        endcase
      end else if (opc == maj_system && s[2]) begin
        w[31:7] = s[3] ? 25'h2000 : 25'h0;
      end
    end
  endtask

  // drives one cycle and queues what the stage must show one edge later.
  task automatic step(input string name, input logic en, input logic br, input logic fl,
                      input logic [31:0] w, input logic wen, input logic [4:0] wreg,
                      input logic [63:0] wval);
    exp_t                 nx;
    dec_op_e              op;
    logic [4:0]           r1;
    logic [4:0]           r2;
    logic [4:0]           rd;
    logic [63:0]          imm;
    logic [`DEC_XLEN-1:0] pc;
    @(posedge clk);
    if (pend_wen && pend_reg != '0) model[pend_reg] = pend_val; // landed at this edge.
    pend_wen = wen;
    pend_reg = wreg;
    pend_val = wval;
    pc = rand64();
    ref_decode(w, op, r1, r2, rd, imm);
    if (fl || (en && br)) begin
      nx    = '0;
      nx.op = op_nop;
    end else if (en) begin
      nx.pc  = pc;
      nx.op  = op;
      nx.r1  = r1;
      nx.r2  = r2;
      nx.rd  = rd;
      nx.v1  = model[r1];
      nx.v2  = model[r2];
      nx.imm = imm;
    end else begin
      nx = cur;
    end
    cur = nx;
    exp_q.push_back(nx);
    due_q.push_back(cycle + 2);
    name_q.push_back(name);
    decode_en     <= en;
    branch_taken  <= br;
    syscall_flush <= fl;
    instr         <= w;
    pc_plus4      <= pc;
    wb_en         <= wen;
    wb_regno      <= wreg;
    wb_value      <= wval;
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] expv, input logic [63:0] actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test, field, expv, actv);
    end
  endtask

  always @(negedge clk) begin : compare
    exp_t  e;
    string nm;
    if (taps_on) begin
      for (int i = 0; i < 8; i++) begin
        check_value("a_regs", $sformatf("a%0d", i), model[10 + i], taps[i]);
      end
    end
    if (exp_q.size() != 0 && due_q[0] <= cycle) begin
      e  = exp_q.pop_front();
      nm = name_q.pop_front();
      void'(due_q.pop_front());
      check_value(nm, "pc_plus4", e.pc, out_pc_plus4);
      check_value(nm, "op", 64'(e.op), 64'(out_op));
      check_value(nm, "rs1_regno", 64'(e.r1), 64'(out_rs1_regno));
      check_value(nm, "rs2_regno", 64'(e.r2), 64'(out_rs2_regno));
      check_value(nm, "rd_regno", 64'(e.rd), 64'(out_rd_regno));
      check_value(nm, "rs1_value", e.v1, out_rs1_value);
      check_value(nm, "rs2_value", e.v2, out_rs2_value);
      check_value(nm, "imm", e.imm, out_imm);
    end
  end

  initial begin
    logic [31:0] w;
    logic [31:0] r;
    clk           = 1'b0;
    rst_n         = 1'b0;
    decode_en     = 1'b0;
    branch_taken  = 1'b0;
    syscall_flush = 1'b0;
    instr         = '0;
    pc_plus4      = '0;
    wb_en         = 1'b0;
    wb_regno      = '0;
    wb_value      = '0;
    pend_wen      = 1'b0;
    pend_reg      = '0;
    pend_val      = '0;
    cur           = '0;
    for (int i = 0; i < `DEC_NREGS; i++) model[i] = '0;
    model[2] = `DEC_SP_RESET;
    repeat (3) @(posedge clk);
    rst_n   <= 1'b1;
    taps_on = 1'b1;

    // reset state, x2 reset value, and a write to x0 that must be dropped.
    step("reset_state", 1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 5'd0, 64'd0);
    step("x2_reset", 1'b1, 1'b0, 1'b0, enc_r(7'd0, 5'd0, 5'd2, 3'b000, 5'd5, maj_op_imm),
         1'b1, 5'd0, rand64());
    step("x0_read", 1'b1, 1'b0, 1'b0, enc_r(7'd0, 5'd2, 5'd0, 3'b000, 5'd7, maj_op),
         1'b0, 5'd0, 64'd0);
    step("x0_read", 1'b1, 1'b0, 1'b0, enc_r(7'd0, 5'd0, 5'd2, 3'b000, 5'd8, maj_op),
         1'b0, 5'd0, 64'd0);

    // writeback then read.
    for (int i = 1; i < `DEC_NREGS; i++) begin
      step("wb_fill", 1'b0, 1'b0, 1'b0, 32'd0, 1'b1, 5'(i), rand64());
    end
    for (int i = 0; i < 60; i++) begin
      r = $random(seed);
      step("wb_read", 1'b1, 1'b0, 1'b0, enc_r(7'd0, r[14:10], r[9:5], 3'b000, r[4:0], maj_op),
           r[15], r[20:16], rand64());
    end

    // decode coverage over every major opcode and funct group.
    for (int i = 0; i < 400; i++) begin
      build_instr(w);
      r = $random(seed);
      step("decode", 1'b1, 1'b0, 1'b0, w, r[0], r[5:1], rand64());
    end

    // branch squash.
    for (int i = 0; i < 4; i++) begin
      build_instr(w);
      step("branch", 1'b1, 1'b1, 1'b0, w, 1'b0, 5'd0, 64'd0);
    end
    w = enc_r(7'd0, 5'd11, 5'd10, 3'b000, 5'd12, maj_op);
    step("branch_prep", 1'b1, 1'b0, 1'b0, w, 1'b0, 5'd0, 64'd0);
    build_instr(w);
    step("branch_stalled", 1'b0, 1'b1, 1'b0, w, 1'b0, 5'd0, 64'd0);
    step("branch_after", 1'b1, 1'b0, 1'b0, w, 1'b0, 5'd0, 64'd0);

    // syscall flush, stalled and enabled.
    w = enc_r(7'd0, 5'd11, 5'd10, 3'b000, 5'd12, maj_op);
    step("flush_prep", 1'b1, 1'b0, 1'b0, w, 1'b0, 5'd0, 64'd0);
    step("flush_stalled", 1'b0, 1'b0, 1'b1, w, 1'b0, 5'd0, 64'd0);
    step("flush_prep", 1'b1, 1'b0, 1'b0, w, 1'b0, 5'd0, 64'd0);
    step("flush_enabled", 1'b1, 1'b0, 1'b1, w, 1'b0, 5'd0, 64'd0);
    step("flush_prep", 1'b1, 1'b0, 1'b0, w, 1'b0, 5'd0, 64'd0);
    step("flush_branch", 1'b1, 1'b1, 1'b1, w, 1'b0, 5'd0, 64'd0);

    // hold while instr keeps changing; addi x5, x2, -4 gives a negative immediate.
    step("hold_load", 1'b1, 1'b0, 1'b0, enc_r(7'h7f, 5'h1c, 5'd2, 3'b000, 5'd5, maj_op_imm),
         1'b0, 5'd0, 64'd0);
    for (int i = 0; i < 6; i++) begin
      build_instr(w);
      step("hold", 1'b0, 1'b0, 1'b0, w, 1'b1, 5'(i + 10), rand64());
    end
    step("idle", 1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 5'd0, 64'd0);
    step("idle", 1'b0, 1'b0, 1'b0, 32'd0, 1'b0, 5'd0, 64'd0);

    while (exp_q.size() != 0) @(negedge clk);
    errors = errors + int'(DUT.u_chk.assert_fails);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/decode_stage_chk.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_stage_chk import decode_pkg::*; (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    decode_en,
  input logic                    syscall_flush,
  input logic [`DEC_XLEN-1:0]    out_pc_plus4,
  input dec_op_e                 out_op,
  input logic [`DEC_REGNO_W-1:0] out_rs1_regno,
  input logic [`DEC_REGNO_W-1:0] out_rs2_regno,
  input logic [`DEC_REGNO_W-1:0] out_rd_regno,
  input logic [`DEC_XLEN-1:0]    out_rs1_value,
  input logic [`DEC_XLEN-1:0]    out_rs2_value,
  input logic [`DEC_XLEN-1:0]    out_imm
);
  int unsigned assert_fails = 0;

  flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    syscall_flush |=> (out_op == op_nop && out_rd_regno == '0)
  ) else begin
    assert_fails++;
    $error("stage register not cleared after a syscall flush");
  end

  // a stall with branch_taken high still holds because the bubble needs decode_en.
  stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (!decode_en && !syscall_flush) |=> ($stable(out_pc_plus4) && $stable(out_op) &&
      $stable(out_rs1_regno) && $stable(out_rs2_regno) && $stable(out_rd_regno) &&
      $stable(out_rs1_value) && $stable(out_rs2_value) && $stable(out_imm))
  ) else begin
    assert_fails++;
    $error("stage outputs changed while decode_en was low");
  end

  x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (out_rs1_regno == '0) |-> (out_rs1_value == '0)
  ) else begin
    assert_fails++;
    $error("rs1 value is not zero for register x0");
  end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_stage import decode_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    decode_en,
  input  logic                    branch_taken,
  input  logic                    syscall_flush,
  input  logic [`DEC_ILEN-1:0]    instr,
  input  logic [`DEC_XLEN-1:0]    pc_plus4,
  input  logic                    wb_en,
  input  logic [`DEC_REGNO_W-1:0] wb_regno,
  input  logic [`DEC_XLEN-1:0]    wb_value,
  output logic [`DEC_XLEN-1:0]    out_pc_plus4,
  output dec_op_e                 out_op,
  output logic [`DEC_REGNO_W-1:0] out_rs1_regno,
  output logic [`DEC_REGNO_W-1:0] out_rs2_regno,
  output logic [`DEC_REGNO_W-1:0] out_rd_regno,
  output logic [`DEC_XLEN-1:0]    out_rs1_value,
  output logic [`DEC_XLEN-1:0]    out_rs2_value,
  output logic [`DEC_XLEN-1:0]    out_imm,
  output logic [`DEC_XLEN-1:0]    a0,
  output logic [`DEC_XLEN-1:0]    a1,
  output logic [`DEC_XLEN-1:0]    a2,
  output logic [`DEC_XLEN-1:0]    a3,
  output logic [`DEC_XLEN-1:0]    a4,
  output logic [`DEC_XLEN-1:0]    a5,
  output logic [`DEC_XLEN-1:0]    a6,
  output logic [`DEC_XLEN-1:0]    a7
);
  dec_op_e                 dec_op;
  logic [`DEC_REGNO_W-1:0] rs1_regno;
  logic [`DEC_REGNO_W-1:0] rs2_regno;
  logic [`DEC_REGNO_W-1:0] rd_regno;
  logic [`DEC_XLEN-1:0]    imm;
  logic [`DEC_XLEN-1:0]    rs1_value;
  logic [`DEC_XLEN-1:0]    rs2_value;

  inst_decoder u_decoder (
    .instr     (instr),
    .op        (dec_op),
    .rs1_regno (rs1_regno),
    .rs2_regno (rs2_regno),
    .rd_regno  (rd_regno),
    .imm       (imm)
  );

  reg_file u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_en     (wb_en),
    .wb_regno  (wb_regno),
    .wb_value  (wb_value),
    .rs1_regno (rs1_regno),
    .rs2_regno (rs2_regno),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .a0        (a0),
    .a1        (a1),
    .a2        (a2),
    .a3        (a3),
    .a4        (a4),
    .a5        (a5),
    .a6        (a6),
    .a7        (a7)
  );

  decode_pipe_reg u_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .decode_en     (decode_en),
    .branch_taken  (branch_taken),
    .syscall_flush (syscall_flush),
    .pc_plus4      (pc_plus4),
    .op            (dec_op),
    .rs1_regno     (rs1_regno),
    .rs2_regno     (rs2_regno),
    .rd_regno      (rd_regno),
    .rs1_value     (rs1_value),
    .rs2_value     (rs2_value),
    .imm           (imm),
    .out_pc_plus4  (out_pc_plus4),
    .out_op        (out_op),
    .out_rs1_regno (out_rs1_regno),
    .out_rs2_regno (out_rs2_regno),
    .out_rd_regno  (out_rd_regno),
    .out_rs1_value (out_rs1_value),
    .out_rs2_value (out_rs2_value),
    .out_imm       (out_imm)
  );

endmodule

`default_nettype wire

//--- src/decode_pipe_reg.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_pipe_reg import decode_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    decode_en,
  input  logic                    branch_taken,
  input  logic                    syscall_flush,
  input  logic [`DEC_XLEN-1:0]    pc_plus4,
  input  dec_op_e                 op,
  input  logic [`DEC_REGNO_W-1:0] rs1_regno,
  input  logic [`DEC_REGNO_W-1:0] rs2_regno,
  input  logic [`DEC_REGNO_W-1:0] rd_regno,
  input  logic [`DEC_XLEN-1:0]    rs1_value,
  input  logic [`DEC_XLEN-1:0]    rs2_value,
  input  logic [`DEC_XLEN-1:0]    imm,
  output logic [`DEC_XLEN-1:0]    out_pc_plus4,
  output dec_op_e                 out_op,
  output logic [`DEC_REGNO_W-1:0] out_rs1_regno,
  output logic [`DEC_REGNO_W-1:0] out_rs2_regno,
  output logic [`DEC_REGNO_W-1:0] out_rd_regno,
  output logic [`DEC_XLEN-1:0]    out_rs1_value,
  output logic [`DEC_XLEN-1:0]    out_rs2_value,
  output logic [`DEC_XLEN-1:0]    out_imm
);
  logic clear;

  // a flush clears even while the stage is stalled.
  assign clear = syscall_flush || (decode_en && branch_taken);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_pc_plus4  <= '0;
      out_op        <= op_nop;
      out_rs1_regno <= '0;
      out_rs2_regno <= '0;
      out_rd_regno  <= '0;
      out_rs1_value <= '0;
      out_rs2_value <= '0;
      out_imm       <= '0;
    end else if (clear) begin
      out_pc_plus4  <= '0;
      out_op        <= op_nop; // the bubble.
      out_rs1_regno <= '0;
      out_rs2_regno <= '0;
      out_rd_regno  <= '0;
      out_rs1_value <= '0;
      out_rs2_value <= '0;
      out_imm       <= '0;
    end else if (decode_en) begin
      out_pc_plus4  <= pc_plus4;
      out_op        <= op;
      out_rs1_regno <= rs1_regno;
      out_rs2_regno <= rs2_regno;
      out_rd_regno  <= rd_regno;
      out_rs1_value <= rs1_value;
      out_rs2_value <= rs2_value;
      out_imm       <= imm;
    end
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wb_en,
  input  logic [`DEC_REGNO_W-1:0] wb_regno,
  input  logic [`DEC_XLEN-1:0]    wb_value,
  input  logic [`DEC_REGNO_W-1:0] rs1_regno,
  input  logic [`DEC_REGNO_W-1:0] rs2_regno,
  output logic [`DEC_XLEN-1:0]    rs1_value,
  output logic [`DEC_XLEN-1:0]    rs2_value,
  output logic [`DEC_XLEN-1:0]    a0,
  output logic [`DEC_XLEN-1:0]    a1,
  output logic [`DEC_XLEN-1:0]    a2,
  output logic [`DEC_XLEN-1:0]    a3,
  output logic [`DEC_XLEN-1:0]    a4,
  output logic [`DEC_XLEN-1:0]    a5,
  output logic [`DEC_XLEN-1:0]    a6,
  output logic [`DEC_XLEN-1:0]    a7
);
  logic [`DEC_XLEN-1:0] regs [`DEC_NREGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `DEC_NREGS; i++) begin
        regs[i] <= '0;
      end
      regs[2] <= `DEC_SP_RESET; // x2 is the stack pointer.
    end else if (wb_en && wb_regno != '0) begin
      regs[wb_regno] <= wb_value;
    end
  end

  // no bypass, so a read in the write cycle still sees the old value.
  assign rs1_value = (rs1_regno == '0) ? '0 : regs[rs1_regno];
  assign rs2_value = (rs2_regno == '0) ? '0 : regs[rs2_regno];

  assign a0 = regs[10];
  assign a1 = regs[11];
  assign a2 = regs[12];
  assign a3 = regs[13];
  assign a4 = regs[14];
  assign a5 = regs[15];
  assign a6 = regs[16];
  assign a7 = regs[17]; // syscall number lives here.

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module inst_decoder import rv_isa_pkg::*, decode_pkg::*; (
  input  logic [`DEC_ILEN-1:0]    instr,
  output dec_op_e                 op,
  output logic [`DEC_REGNO_W-1:0] rs1_regno,
  output logic [`DEC_REGNO_W-1:0] rs2_regno,
  output logic [`DEC_REGNO_W-1:0] rd_regno,
  output logic [`DEC_XLEN-1:0]    imm
);
  logic [6:0]          funct7;
  logic [2:0]          funct3;
  dec_op_e             dec_op;
  imm_fmt_e            fmt;
  logic                r_type;
  logic                legal;
  logic                use_rd;
  logic                use_rs1;
  logic                use_rs2;
  logic [`DEC_XLEN-1:0] imm_raw;

  assign funct7 = instr[31:25];
  assign funct3 = instr[14:12];

  always_comb begin
    dec_op = op_illegal;
    fmt    = imm_none;
    r_type = 1'b0;
    case (major_op_e'(instr[6:0]))
      maj_lui: begin
        dec_op = op_lui;
        fmt    = imm_u;
      end
      maj_auipc: begin
        dec_op = op_auipc;
        fmt    = imm_u;
      end
      maj_jal: begin
        dec_op = op_jal;
        fmt    = imm_j;
      end
      maj_jalr: begin
        fmt = imm_i;
        if (funct3 == 3'b000) dec_op = op_jalr;
      end
      maj_branch: begin
        fmt = imm_b;
        case (branch_f3_e'(funct3))
          br_beq:  dec_op = op_beq;
          br_bne:  dec_op = op_bne;
          br_blt:  dec_op = op_blt;
          br_bge:  dec_op = op_bge;
          br_bltu: dec_op = op_bltu;
          br_bgeu: dec_op = op_bgeu;
          default: dec_op = op_illegal;
        endcase
      end
      maj_load: begin
        fmt = imm_i;
        case (load_f3_e'(funct3))
          ld_lb:   dec_op = op_lb;
          ld_lh:   dec_op = op_lh;
          ld_lw:   dec_op = op_lw;
          ld_ld:   dec_op = op_ld;
          ld_lbu:  dec_op = op_lbu;
          ld_lhu:  dec_op = op_lhu;
          ld_lwu:  dec_op = op_lwu;
          default: dec_op = op_illegal;
        endcase
      end
      maj_store: begin
        fmt = imm_s;
        case (store_f3_e'(funct3))
          st_sb:   dec_op = op_sb;
          st_sh:   dec_op = op_sh;
          st_sw:   dec_op = op_sw;
          st_sd:   dec_op = op_sd;
          default: dec_op = op_illegal;
        endcase
      end
      maj_op_imm: begin
        fmt = imm_i; // shifts keep the whole I field, so srai carries bit 10 in imm.
        case (alu_f3_e'(funct3))
          alu_add:  dec_op = op_addi;
          alu_slt:  dec_op = op_slti;
          alu_sltu: dec_op = op_sltiu;
          alu_xor:  dec_op = op_xori;
          alu_or:   dec_op = op_ori;
          alu_and:  dec_op = op_andi;
          alu_sll:  dec_op = (funct7[6:1] == 6'b000000) ? op_slli : op_illegal;
          alu_sr: begin
            if (funct7[6:1] == 6'b000000) dec_op = op_srli;
            else if (funct7[6:1] == 6'b010000) dec_op = op_srai;
          end
          default:  dec_op = op_illegal;
        endcase
      end
      maj_op_imm_32: begin
        fmt = imm_i;
        if (funct3 == 3'b000) dec_op = op_addiw;
        else if (funct3 == 3'b001 && funct7 == 7'b0000000) dec_op = op_slliw;
        else if (funct3 == 3'b101 && funct7 == 7'b0000000) dec_op = op_srliw;
        else if (funct3 == 3'b101 && funct7 == 7'b0100000) dec_op = op_sraiw;
      end
      maj_op: begin
        r_type = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (alu_f3_e'(funct3))
            alu_add:  dec_op = op_add;
            alu_sll:  dec_op = op_sll;
            alu_slt:  dec_op = op_slt;
            alu_sltu: dec_op = op_sltu;
            alu_xor:  dec_op = op_xor;
            alu_sr:   dec_op = op_srl;
            alu_or:   dec_op = op_or;
            alu_and:  dec_op = op_and;
            default:  dec_op = op_illegal;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) dec_op = op_sub;
          else if (funct3 == 3'b101) dec_op = op_sra;
        end
      end
      maj_op_32: begin
        r_type = 1'b1;
        if (funct7 == 7'b0000000) begin
          if (funct3 == 3'b000) dec_op = op_addw;
          else if (funct3 == 3'b001) dec_op = op_sllw;
          else if (funct3 == 3'b101) dec_op = op_srlw;
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) dec_op = op_subw;
          else if (funct3 == 3'b101) dec_op = op_sraw;
        end
      end
      maj_system: begin
        if (instr[19:7] == 13'd0 && instr[31:20] == 12'h000) dec_op = op_ecall;
        else if (instr[19:7] == 13'd0 && instr[31:20] == 12'h001) dec_op = op_ebreak;
      end
      default: dec_op = op_illegal;
    endcase
  end

  always_comb begin
    case (fmt)
      imm_i:   imm_raw = {{(`DEC_XLEN-12){instr[31]}}, instr[31:20]};
      imm_s:   imm_raw = {{(`DEC_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:   imm_raw = {{(`DEC_XLEN-13){instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
      imm_u:   imm_raw = {{(`DEC_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
      imm_j:   imm_raw = {{(`DEC_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
      default: imm_raw = '0;
    endcase
  end

  assign legal   = (dec_op != op_illegal);
  assign use_rd  = legal && (r_type || fmt == imm_i || fmt == imm_u || fmt == imm_j);
  assign use_rs1 = legal && (r_type || fmt == imm_i || fmt == imm_s || fmt == imm_b);
  assign use_rs2 = legal && (r_type || fmt == imm_s || fmt == imm_b);

  assign op        = dec_op;
  assign rd_regno  = use_rd ? instr[11:7] : '0;
  assign rs1_regno = use_rs1 ? instr[19:15] : '0;
  assign rs2_regno = use_rs2 ? instr[24:20] : '0;
  assign imm       = legal ? imm_raw : '0; // unknown encodings carry no immediate.

endmodule

`default_nettype wire

//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // op_nop must stay at zero so a cleared stage register reads as a bubble.
  typedef enum logic [5:0] {
    op_nop = 6'd0,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_lb,
    op_lh,
    op_lw,
    op_ld,
    op_lbu,
    op_lhu,
    op_lwu,
    op_sb,
    op_sh,
    op_sw,
    op_sd,
    op_addi,
    op_slti,
    op_sltiu,
    op_xori,
    op_ori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_addiw,
    op_slliw,
    op_srliw,
    op_sraiw,
    op_addw,
    op_subw,
    op_sllw,
    op_srlw,
    op_sraw,
    op_ecall,
    op_ebreak,
    op_illegal
  } dec_op_e;

  typedef enum logic [2:0] {
    imm_none = 3'd0,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_e;

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcode field, instr[6:0].
  typedef enum logic [6:0] {
    maj_lui       = 7'b0110111,
    maj_auipc     = 7'b0010111,
    maj_jal       = 7'b1101111,
    maj_jalr      = 7'b1100111,
    maj_branch    = 7'b1100011,
    maj_load      = 7'b0000011,
    maj_store     = 7'b0100011,
    maj_op_imm    = 7'b0010011,
    maj_op        = 7'b0110011,
    maj_op_imm_32 = 7'b0011011,
    maj_op_32     = 7'b0111011,
    maj_system    = 7'b1110011
  } major_op_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_f3_e;

  typedef enum logic [2:0] {
    ld_lb  = 3'b000,
    ld_lh  = 3'b001,
    ld_lw  = 3'b010,
    ld_ld  = 3'b011,
    ld_lbu = 3'b100,
    ld_lhu = 3'b101,
    ld_lwu = 3'b110
  } load_f3_e;

  typedef enum logic [2:0] {
    st_sb = 3'b000,
    st_sh = 3'b001,
    st_sw = 3'b010,
    st_sd = 3'b011
  } store_f3_e;

  // shared by op, op_imm and their 32-bit forms; alu_sr covers srl and sra.
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_sr   = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_f3_e;

endpackage

`default_nettype wire

//--- src/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// register and address width.
`define DEC_XLEN 64

// number of architectural integer registers.
`define DEC_NREGS 32

// bits needed to name one register.
`define DEC_REGNO_W 5

// instruction word width.
`define DEC_ILEN 32

// initial stack pointer, loaded into x2 on reset.
`define DEC_SP_RESET 64'h0000_0000_8000_0000

`endif
